// File: bench/lwe_axil_bfm.svh
// AXI4-Lite host tasks
// hold is the number of cycles the response is kept waiting

task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input int hold);
    int         cycles;
    logic [1:0] held_resp;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (hold == 0);
    cycles  = 0;
    @(posedge clk);
    while (!(awready && wready)) begin
        if (cycles == TIMEOUT_CYCLES) begin
            stop_on_timeout("write address and data were never accepted");
        end
        cycles++;
        @(posedge clk);
    end
    // request stays up, so a second accept would show on awready
    for (int n = 0; n < hold; n++) begin
        @(posedge clk);
        if (n == 0) begin
            held_resp = bresp;
        end
        assert (bvalid && !awready && !wready)
            else protocol_error("write response was not held, or a new write was taken");
        assert (bresp === held_resp) else report_mismatch("bresp", held_resp, bresp);
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    cycles  = 0;
    @(posedge clk);
    while (!(bvalid && bready)) begin
        if (cycles == TIMEOUT_CYCLES) begin
            stop_on_timeout("write response never arrived");
        end
        cycles++;
        @(posedge clk);
    end
endtask

task automatic axil_read(input logic [ADDR_W-1:0] addr, input int hold,
                         output logic [DATA_W-1:0] data);
    int                cycles;
    logic [DATA_W-1:0] held_data;
    logic [1:0]        held_resp;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (hold == 0);
    cycles  = 0;
    @(posedge clk);
    while (!arready) begin
        if (cycles == TIMEOUT_CYCLES) begin
            stop_on_timeout("read address was never accepted");
        end
        cycles++;
        @(posedge clk);
    end
    for (int n = 0; n < hold; n++) begin
        @(posedge clk);
        if (n == 0) begin
            held_data = rdata;
            held_resp = rresp;
        end
        assert (rvalid && !arready)
            else protocol_error("read response was not held, or a new read was taken");
        assert (rdata === held_data) else report_mismatch("rdata", held_data, rdata);
        assert (rresp === held_resp) else report_mismatch("rresp", held_resp, rresp);
    end
    @(negedge clk);
    arvalid = 1'b0;
    rready  = 1'b1;
    cycles  = 0;
    @(posedge clk);
    while (!(rvalid && rready)) begin
        if (cycles == TIMEOUT_CYCLES) begin
            stop_on_timeout("read response never arrived");
        end
        cycles++;
        @(posedge clk);
    end
    data = rdata;
endtask

// File: bench/lwe_keygen_tb.sv
`timescale 1ns/100ps

module lwe_keygen_tb;

    import lwe_regs_pkg::*;

    localparam int unsigned       Q              = 3329;
    localparam logic [ADDR_W-1:0] BASE_ADDR      = 32'h4000_6000;
    localparam int                TIMEOUT_CYCLES = 100;
    localparam int                POLL_LIMIT     = 40;

    // byte offsets inside the register window
    localparam int OFF_S        = 'h40;
    localparam int OFF_E        = 'h50;
    localparam int OFF_T        = 'h60;
    localparam int OFF_CTRL     = 'h70;
    localparam int OFF_STATUS   = 'h74;
    localparam int OFF_UNMAPPED = 'h78;

    logic              clk;
    logic              rst_n;
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic              bvalid;
    logic              bready;
    logic [1:0]        bresp;
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;

    // operands as the host sees them, already reduced
    logic [3:0][3:0][11:0] model_a;
    logic [3:0][11:0]      model_s;
    logic [3:0][11:0]      model_e;

    // {check, resp, data} for reads, resp for writes
    logic [1:0]  wr_exp[$];
    logic [34:0] rd_exp[$];

    int          mismatches      = 0;
    int          protocol_errors = 0;
    int          timeouts        = 0;
    int unsigned seed;

    lwe_keygen_top #(
        .Q(Q),
        .BASE_ADDR(BASE_ADDR)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
        mismatches++;
    endtask

    task automatic protocol_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        protocol_errors++;
    endtask

    task automatic end_run();
        $display("errors: %0d value mismatches, %0d protocol errors, %0d timeouts",
                 mismatches, protocol_errors, timeouts);
        if (mismatches + protocol_errors + timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string msg);
        $display("Timed out at %0t ns: %s", $time, msg);
        timeouts++;
        end_run();
    endtask

    `include "lwe_axil_bfm.svh"

    // t[row] = (sum of A[row][col] * s[col] + e[row]) mod Q
    function automatic logic [31:0] reference_t(input logic [3:0][3:0][11:0] a,
                                                input logic [3:0][11:0] s,
                                                input logic [3:0][11:0] e,
                                                input int row);
        longint unsigned sum;
        sum = 64'(e[row]);
        for (int col = 0; col < 4; col++) begin
            sum = sum + 64'(a[row][col]) * 64'(s[col]);
        end
        return 32'(sum % Q);
    endfunction

    function automatic logic [ADDR_W-1:0] reg_addr(input int offset);
        return BASE_ADDR + ADDR_W'(offset);
    endfunction

    task automatic write_expect(input int offset, input logic [31:0] data,
                                input logic [1:0] resp);
        wr_exp.push_back(resp);
        axil_write(reg_addr(offset), data, 0);
    endtask

    task automatic read_expect(input int offset, input logic [31:0] data,
                               input logic [1:0] resp);
        logic [31:0] unused;
        rd_exp.push_back({1'b1, resp, data});
        axil_read(reg_addr(offset), 0, unused);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = '0;
        // bit 0 busy, bit 1 done
        while (!(status[1] && !status[0])) begin
            if (polls == POLL_LIMIT) begin
                stop_on_timeout("engine never reported done");
            end
            polls++;
            rd_exp.push_back('0);
            axil_read(reg_addr(OFF_STATUS), 0, status);
        end
    endtask

    task automatic check_t();
        for (int i = 0; i < 4; i++) begin
            read_expect(OFF_T + 4 * i, reference_t(model_a, model_s, model_e, i), RESP_OKAY);
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        assert (!bvalid && !rvalid) else protocol_error("response valid before any request");
        read_expect(OFF_STATUS, 32'h0, RESP_OKAY);
        for (int i = 0; i < 4; i++) begin
            read_expect(OFF_T + 4 * i, 32'h0, RESP_OKAY);
        end
    endtask

    task automatic check_reduction();
        logic [31:0] word;
        // A, s and e sit back to back from offset 0
        for (int i = 0; i < 24; i++) begin
            word = $urandom;
            if (i < 16) begin
                model_a[i / 4][i % 4] = word % Q;
            end else if (i < 20) begin
                model_s[i - 16] = word % Q;
            end else begin
                model_e[i - 20] = word % Q;
            end
            write_expect(4 * i, word, RESP_OKAY);
            read_expect(4 * i, word % Q, RESP_OKAY);
        end
    endtask

    task automatic run_keygen();
        write_expect(OFF_CTRL, 32'h1, RESP_OKAY);
        wait_done();
        check_t();
    endtask

    task automatic check_refused();
        write_expect(OFF_T, $urandom, RESP_SLVERR);
        write_expect(OFF_STATUS, 32'h0, RESP_SLVERR);
        check_t();
        read_expect(OFF_STATUS, 32'h2, RESP_OKAY);
        read_expect(OFF_UNMAPPED, 32'h0, RESP_SLVERR);
        // one window below the base, its low bits alias CTRL
        wr_exp.push_back(RESP_SLVERR);
        axil_write(reg_addr(OFF_CTRL) - 'h80, 32'h1, 0);
        // nothing started, done still set
        read_expect(OFF_STATUS, 32'h2, RESP_OKAY);
    endtask

    task automatic check_busy_lockout();
        logic [31:0] word;
        word = $urandom;
        model_e[1] = word % Q;
        write_expect(OFF_E + 4, word, RESP_OKAY);
        write_expect(OFF_CTRL, 32'h1, RESP_OKAY);
        write_expect(OFF_S, 32'h5, RESP_SLVERR);
        write_expect(OFF_CTRL, 32'h1, RESP_SLVERR);
        wait_done();
        read_expect(OFF_S, model_s[0], RESP_OKAY);
        check_t();
    endtask

    task automatic check_back_pressure();
        logic [31:0] word;
        logic [31:0] unused;
        word = $urandom;
        model_a[2][3] = word % Q;
        wr_exp.push_back(RESP_OKAY);
        axil_write(reg_addr(4 * (2 * 4 + 3)), word, 6);
        rd_exp.push_back({1'b1, RESP_OKAY, 32'(model_a[2][3])});
        axil_read(reg_addr(4 * (2 * 4 + 3)), 6, unused);
    endtask

    // each response is checked when the host takes it
    always @(posedge clk) begin
        logic [1:0]  exp_b;
        logic [34:0] exp_r;
        if (bvalid && bready) begin
            if (wr_exp.size() == 0) begin
                protocol_error("write response with no write outstanding");
            end else begin
                exp_b = wr_exp.pop_front();
                assert (bresp === exp_b) else report_mismatch("bresp", exp_b, bresp);
            end
        end
        if (rvalid && rready) begin
            if (rd_exp.size() == 0) begin
                protocol_error("read response with no read outstanding");
            end else begin
                exp_r = rd_exp.pop_front();
                if (exp_r[34]) begin
                    assert (rresp === exp_r[33:32])
                        else report_mismatch("rresp", exp_r[33:32], rresp);
                    assert (rdata === exp_r[31:0])
                        else report_mismatch("rdata", exp_r[31:0], rdata);
                end
            end
        end
    end

    initial begin
        seed    = $urandom(84051);
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        model_a = '0;
        model_s = '0;
        model_e = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        check_reduction();
        run_keygen();
        check_refused();
        check_busy_lockout();
        check_back_pressure();

        @(negedge clk);
        assert (wr_exp.size() == 0 && rd_exp.size() == 0)
            else protocol_error("some expected responses never arrived");
        end_run();
    end

endmodule

// File: build.f
src/lwe_pkg.sv
src/lwe_regs_pkg.sv
src/lwe_axil_slave.sv
src/lwe_reg_file.sv
src/lwe_keygen_engine.sv
src/lwe_keygen_top.sv
+incdir+bench
bench/lwe_keygen_tb.sv

// File: src/lwe_axil_slave.sv
`timescale 1ns/100ps

module lwe_axil_slave #(
    parameter logic [lwe_regs_pkg::ADDR_W-1:0] BASE_ADDR = 32'h4000_6000
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [lwe_regs_pkg::ADDR_W-1:0] awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [lwe_regs_pkg::DATA_W-1:0] wdata,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [lwe_regs_pkg::ADDR_W-1:0] araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [lwe_regs_pkg::DATA_W-1:0] rdata,
    output logic [1:0]                      rresp,
    output lwe_regs_pkg::reg_wr_t           reg_wr,
    output lwe_regs_pkg::reg_rd_t           reg_rd,
    input  lwe_regs_pkg::reg_rsp_t          wr_rsp,
    input  lwe_regs_pkg::reg_rsp_t          rd_rsp
);

    import lwe_regs_pkg::*;

    localparam logic [ADDR_W-1:0] WINDOW = ADDR_W'(1) << (IDX_W + 2);

    logic [ADDR_W-1:0] aw_off;
    logic [ADDR_W-1:0] ar_off;
    logic              aw_hit;
    logic              ar_hit;
    logic              wr_accept;
    logic              rd_accept;

    // below the base the offset wraps to a large value and misses too
    assign aw_off = awaddr - BASE_ADDR;
    assign ar_off = araddr - BASE_ADDR;
    assign aw_hit = (aw_off < WINDOW);
    assign ar_hit = (ar_off < WINDOW);

    // address and data are taken together, and only with no response held
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;

    assign reg_wr.valid = wr_accept && aw_hit;
    assign reg_wr.idx   = aw_off[IDX_W+1:2];
    assign reg_wr.data  = wdata;
    assign reg_rd.valid = rd_accept && ar_hit;
    assign reg_rd.idx   = ar_off[IDX_W+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payload, loaded on accept and held after
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= (aw_hit && !wr_rsp.err) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_accept) begin
            rdata <= ar_hit ? rd_rsp.data : '0;
            rresp <= (ar_hit && !rd_rsp.err) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // a response waits for the host, unchanged
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// File: src/lwe_keygen_engine.sv
`timescale 1ns/100ps

module lwe_keygen_engine #(
    parameter int unsigned Q = 3329
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lwe_pkg::lwe_matrix_t mat_a,
    input  lwe_pkg::lwe_vector_t vec_s,
    input  lwe_pkg::lwe_vector_t vec_e,
    input  logic                 start,
    output logic                 busy,
    output logic                 result_valid,
    output lwe_pkg::lwe_vector_t result
);

    import lwe_pkg::*;

    lwe_matrix_t          a_q;
    lwe_vector_t          s_q;
    lwe_vector_t          e_q;
    lwe_vector_t          t_q;
    acc_t                 acc;
    logic [$clog2(N)-1:0] row;
    logic [$clog2(N)-1:0] col;
    logic                 reduce;
    logic [2*COEFF_W-1:0] product;
    coeff_t               row_sum;

    function automatic logic below_q(input lwe_vector_t v);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < N; i++) begin
            ok = ok && (v[i] < Q);
        end
        return ok;
    endfunction

    assign product = a_q[row][col] * s_q[col];
    assign row_sum = mod_q(acc + acc_t'(e_q[row]), acc_t'(Q));

    // four mac cycles then one reduce cycle per row, 20 in all
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            row    <= '0;
            col    <= '0;
            reduce <= 1'b0;
        end else if (start && !busy) begin
            busy   <= 1'b1;
            row    <= '0;
            col    <= '0;
            reduce <= 1'b0;
        end else if (busy) begin
            if (!reduce) begin
                col    <= col + 1'b1;
                reduce <= (col == N-1);
            end else begin
                reduce <= 1'b0;
                row    <= row + 1'b1;
                busy   <= (row != N-1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            a_q <= mat_a;
            s_q <= vec_s;
            e_q <= vec_e;
            acc <= '0;
        end else if (busy) begin
            if (!reduce) begin
                acc <= acc + acc_t'(product);
            end else begin
                acc      <= '0;
                t_q[row] <= row_sum;
            end
        end
    end

    // last row goes out in the cycle that stores it
    always_comb begin
        result = t_q;
        if (reduce) begin
            result[row] = row_sum;
        end
    end

    assign result_valid = busy && reduce && (row == N-1);

    assert property (@(posedge clk) disable iff (!rst_n) $fell(busy) |-> below_q(t_q));

endmodule

// File: src/lwe_keygen_top.sv
`timescale 1ns/100ps

module lwe_keygen_top #(
    parameter int unsigned                     Q         = 3329,
    parameter logic [lwe_regs_pkg::ADDR_W-1:0] BASE_ADDR = 32'h4000_6000
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [lwe_regs_pkg::ADDR_W-1:0] awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [lwe_regs_pkg::DATA_W-1:0] wdata,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [lwe_regs_pkg::ADDR_W-1:0] araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [lwe_regs_pkg::DATA_W-1:0] rdata,
    output logic [1:0]                      rresp
);

    import lwe_pkg::*;
    import lwe_regs_pkg::*;

    reg_wr_t     reg_wr;
    reg_rd_t     reg_rd;
    reg_rsp_t    wr_rsp;
    reg_rsp_t    rd_rsp;
    lwe_matrix_t mat_a;
    lwe_vector_t vec_s;
    lwe_vector_t vec_e;
    lwe_vector_t result;
    logic        start;
    logic        busy;
    logic        result_valid;

    lwe_axil_slave #(.BASE_ADDR(BASE_ADDR)) u_slave (.*);

    lwe_reg_file #(.Q(Q)) u_reg_file (.*);

    lwe_keygen_engine #(.Q(Q)) u_engine (.*);

endmodule

// File: src/lwe_pkg.sv
package lwe_pkg;

    // vector length and coefficient width of the scheme
    localparam int N       = 4;
    localparam int COEFF_W = 12;
    localparam int ACC_W   = 32;

    typedef logic [COEFF_W-1:0] coeff_t;

    // element 0 sits in the low bits
    typedef coeff_t [N-1:0] lwe_vector_t;

    // row-major, indexed as mat[row][col]
    typedef lwe_vector_t [N-1:0] lwe_matrix_t;

    // four 24-bit products plus e stay far below 2**32
    typedef logic [ACC_W-1:0] acc_t;

    // remainder of value by q, q always fits in a coefficient
    function automatic coeff_t mod_q(input acc_t value, input acc_t q);
        acc_t rem;
        rem = value % q;
        return rem[COEFF_W-1:0];
    endfunction

endpackage

// File: src/lwe_reg_file.sv
`timescale 1ns/100ps

module lwe_reg_file #(
    parameter int unsigned Q = 3329
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lwe_regs_pkg::reg_wr_t  reg_wr,
    input  lwe_regs_pkg::reg_rd_t  reg_rd,
    input  logic                   busy,
    output lwe_regs_pkg::reg_rsp_t wr_rsp,
    output lwe_regs_pkg::reg_rsp_t rd_rsp,
    output lwe_pkg::lwe_matrix_t   mat_a,
    output lwe_pkg::lwe_vector_t   vec_s,
    output lwe_pkg::lwe_vector_t   vec_e,
    output logic                   start,
    input  logic                   result_valid,
    input  lwe_pkg::lwe_vector_t   result
);

    import lwe_pkg::*;
    import lwe_regs_pkg::*;

    reg_idx_u    wr_idx;
    reg_idx_u    rd_idx;
    coeff_t      wr_coeff;
    logic        wr_err;
    logic        wr_ok;
    logic        ctrl_wr;
    lwe_vector_t vec_t;
    logic        done;

    assign wr_idx   = reg_wr.idx;
    assign rd_idx   = reg_rd.idx;
    assign wr_coeff = mod_q(acc_t'(reg_wr.data), acc_t'(Q));

    // operands are locked while the engine runs; t and status are read-only
    always_comb begin
        ctrl_wr = 1'b0;
        if (!wr_idx.mat.region) begin
            wr_err = busy;
        end else begin
            case (wr_idx.vec.region)
                REGION_S, REGION_E: wr_err = busy;
                REGION_CTRL: begin
                    ctrl_wr = (wr_idx.vec.elem == ELEM_CTRL);
                    wr_err  = busy || !ctrl_wr;
                end
                default: wr_err = 1'b1;
            endcase
        end
    end

    assign wr_ok       = reg_wr.valid && !wr_err;
    assign start       = wr_ok && ctrl_wr && reg_wr.data[0];
    assign wr_rsp.data = '0;
    assign wr_rsp.err  = wr_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mat_a <= '0;
            vec_s <= '0;
            vec_e <= '0;
            vec_t <= '0;
            done  <= 1'b0;
        end else begin
            if (wr_ok) begin
                if (!wr_idx.mat.region) begin
                    mat_a[wr_idx.mat.row][wr_idx.mat.col] <= wr_coeff;
                end else if (wr_idx.vec.region == REGION_S) begin
                    vec_s[wr_idx.vec.elem] <= wr_coeff;
                end else if (wr_idx.vec.region == REGION_E) begin
                    vec_e[wr_idx.vec.elem] <= wr_coeff;
                end
            end
            if (result_valid) begin
                vec_t <= result;
            end
            if (start) begin
                done <= 1'b0;
            end else if (result_valid) begin
                done <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_rsp = '0;
        if (reg_rd.valid) begin
            if (!rd_idx.mat.region) begin
                rd_rsp.data = DATA_W'(mat_a[rd_idx.mat.row][rd_idx.mat.col]);
            end else begin
                case (rd_idx.vec.region)
                    REGION_S: rd_rsp.data = DATA_W'(vec_s[rd_idx.vec.elem]);
                    REGION_E: rd_rsp.data = DATA_W'(vec_e[rd_idx.vec.elem]);
                    REGION_T: rd_rsp.data = DATA_W'(vec_t[rd_idx.vec.elem]);
                    default: begin
                        if (rd_idx.vec.elem == ELEM_STATUS) begin
                            rd_rsp.data = {{(DATA_W-2){1'b0}}, done, busy};
                        end else begin
                            rd_rsp.err = 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // engine is idle on every start, and picks it up at once
    assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);
    assert property (@(posedge clk) disable iff (!rst_n) start |=> busy && !done);

endmodule

// File: src/lwe_regs_pkg.sv
package lwe_regs_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // word index inside the 128-byte register window
    localparam int IDX_W  = 5;

    // A[row][col] lives at word offsets 0 to 15
    typedef struct packed {
        logic       region;
        logic [1:0] row;
        logic [1:0] col;
    } mat_idx_t;

    // s, e, t and control, four words each
    typedef struct packed {
        logic [2:0] region;
        logic [1:0] elem;
    } vec_idx_t;

    // one word index, read either as a matrix cell or as a vector element
    typedef union packed {
        mat_idx_t mat;
        vec_idx_t vec;
    } reg_idx_u;

    localparam logic [2:0] REGION_S    = 3'd4;
    localparam logic [2:0] REGION_E    = 3'd5;
    localparam logic [2:0] REGION_T    = 3'd6;
    localparam logic [2:0] REGION_CTRL = 3'd7;

    // elements of the control region
    localparam logic [1:0] ELEM_CTRL   = 2'd0;
    localparam logic [1:0] ELEM_STATUS = 2'd1;

    typedef struct packed {
        logic              valid;
        reg_idx_u          idx;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic     valid;
        reg_idx_u idx;
    } reg_rd_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              err;
    } reg_rsp_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
